// ==== rtl/bomb_audio_pkg.sv ====
`default_nettype none

package bomb_audio_pkg;

  // countdown time fields
  typedef logic [2:0] min_t;
  // 0 to 5
  typedef logic [2:0] sec_ten_t;
  // 0 to 9
  typedef logic [3:0] sec_one_t;

  // apb bus widths
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // voice index in the order of the status busy bits
  typedef enum logic [1:0] {
    VOICE_TICK = 2'd0,
    VOICE_PZL  = 2'd1,
    VOICE_BOOM = 2'd2,
    VOICE_ERR  = 2'd3
  } voice_e;

  // per voice fsm
  typedef enum logic {
    IDLE = 1'b0,
    PLAY = 1'b1
  } voice_state_e;

  // register map
  // bit0 run, bit1 load (self clearing)
  localparam apb_addr_t ADDR_CTRL   = 8'h00;
  // load value on write, live count on read
  localparam apb_addr_t ADDR_TIME   = 8'h04;
  // bit0 error, bit1 module clear
  localparam apb_addr_t ADDR_EVENT  = 8'h08;
  // busy per voice and expired, read only
  localparam apb_addr_t ADDR_STATUS = 8'h0C;

endpackage

`default_nettype wire

// ==== rtl/game_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface game_ctrl_if;
  import bomb_audio_pkg::*;

  // host controls, all from the register block
  logic     load;
  min_t     load_min;
  sec_ten_t load_sec_ten;
  sec_one_t load_sec_one;
  logic     run;
  // one cycle event pulses
  logic     err_evt;
  logic     pzl_evt;

  // live countdown state
  min_t     cnt_min;
  sec_ten_t cnt_sec_ten;
  sec_one_t cnt_sec_one;
  logic     expired;
  // 1 Hz, 2 Hz and 4 Hz strobes
  logic     s_strobe;
  logic     s_strobe_fast;
  logic     s_strobe_faster;

  // voice activity, indexed by voice_e
  logic [3:0] busy;

  modport regs (
    output load, load_min, load_sec_ten, load_sec_one, run, err_evt, pzl_evt,
    input  cnt_min, cnt_sec_ten, cnt_sec_one, expired, busy
  );

  modport timer (
    input  load, load_min, load_sec_ten, load_sec_one, run,
    output cnt_min, cnt_sec_ten, cnt_sec_one, expired,
    output s_strobe, s_strobe_fast, s_strobe_faster
  );

  modport audio (
    input  cnt_min, cnt_sec_ten, cnt_sec_one, expired,
    input  s_strobe, s_strobe_fast, s_strobe_faster,
    input  err_evt, pzl_evt,
    output busy
  );

endinterface

`default_nettype wire

// ==== rtl/game_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_apb_regs (
  input  logic                      clk,
  input  logic                      nrst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  bomb_audio_pkg::apb_addr_t paddr,
  input  bomb_audio_pkg::apb_data_t pwdata,
  output bomb_audio_pkg::apb_data_t prdata,
  output logic                      pready,
  output logic                      pslverr,
  game_ctrl_if.regs                 ctl
);
  import bomb_audio_pkg::*;

  logic      access;
  logic      bad_addr;
  logic      wr_en;
  apb_data_t rdata;

  // second cycle of a transfer
  assign access = psel & penable;

  // misaligned, past the map, or a write to status
  assign bad_addr = (paddr[1:0] != 2'b00) || (paddr > ADDR_STATUS) ||
                    (pwrite && (paddr == ADDR_STATUS));

  // erroring writes are dropped
  assign wr_en = access & pwrite & ~bad_addr;

  // never any wait states
  assign pready  = 1'b1;
  assign pslverr = access & bad_addr;

  // read mux
  always_comb begin
    rdata = '0;
    case (paddr)
      ADDR_CTRL: begin
        // load always reads back as zero
        rdata[0] = ctl.run;
      end
      ADDR_TIME: begin
        rdata[3:0]  = ctl.cnt_sec_one;
        rdata[6:4]  = ctl.cnt_sec_ten;
        rdata[10:8] = ctl.cnt_min;
      end
      ADDR_STATUS: begin
        rdata[3:0] = ctl.busy;
        rdata[4]   = ctl.expired;
      end
      default: begin
        // event register reads as zero
        rdata = '0;
      end
    endcase
  end

  // data only during a good read access
  assign prdata = (access && !pwrite && !bad_addr) ? rdata : '0;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      ctl.run          <= 1'b0;
      ctl.load         <= 1'b0;
      ctl.err_evt      <= 1'b0;
      ctl.pzl_evt      <= 1'b0;
      ctl.load_min     <= '0;
      ctl.load_sec_ten <= '0;
      ctl.load_sec_one <= '0;
    end else begin
      // pulses drop after one cycle
      ctl.load    <= 1'b0;
      ctl.err_evt <= 1'b0;
      ctl.pzl_evt <= 1'b0;
      if (wr_en) begin
        case (paddr)
          ADDR_CTRL: begin
            ctl.run  <= pwdata[0];
            ctl.load <= pwdata[1];
          end
          ADDR_TIME: begin
            ctl.load_min     <= pwdata[10:8];
            ctl.load_sec_ten <= pwdata[6:4];
            ctl.load_sec_one <= pwdata[3:0];
            // a time write also preloads the counter
            ctl.load         <= 1'b1;
          end
          ADDR_EVENT: begin
            ctl.err_evt <= pwdata[0];
            ctl.pzl_evt <= pwdata[1];
          end
          default: begin
            ctl.load <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/countdown_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module countdown_timer #(
  parameter int TICKS_PER_SEC = 16
) (
  input  logic       clk,
  input  logic       nrst,
  game_ctrl_if.timer ctl
);
  import bomb_audio_pkg::*;

  localparam int PRE_W = $clog2(TICKS_PER_SEC);
  localparam int QTR   = TICKS_PER_SEC / 4;
  // last count of each quarter second
  localparam logic [PRE_W-1:0] PRE_Q1 = PRE_W'(QTR - 1);
  localparam logic [PRE_W-1:0] PRE_Q2 = PRE_W'(2 * QTR - 1);
  localparam logic [PRE_W-1:0] PRE_Q3 = PRE_W'(3 * QTR - 1);
  localparam logic [PRE_W-1:0] PRE_Q4 = PRE_W'(TICKS_PER_SEC - 1);

  logic [PRE_W-1:0] pre;
  logic             counting;
  logic             wrap;
  logic             at_zero;
  logic             at_last;
  min_t             nxt_min;
  sec_ten_t         nxt_sec_ten;
  sec_one_t         nxt_sec_one;

  // stops by itself once expired
  assign counting = ctl.run & ~ctl.expired;
  assign wrap     = counting && (pre == PRE_Q4);

  assign at_zero = (ctl.cnt_min == '0) && (ctl.cnt_sec_ten == '0) && (ctl.cnt_sec_one == '0);
  // one second left
  assign at_last = (ctl.cnt_min == '0) && (ctl.cnt_sec_ten == '0) &&
                   (ctl.cnt_sec_one == 4'd1);

  // base 60 borrow chain
  always_comb begin
    nxt_min     = ctl.cnt_min;
    nxt_sec_ten = ctl.cnt_sec_ten;
    nxt_sec_one = ctl.cnt_sec_one - 4'd1;
    if (ctl.cnt_sec_one == '0) begin
      nxt_sec_one = 4'd9;
      nxt_sec_ten = ctl.cnt_sec_ten - 3'd1;
      if (ctl.cnt_sec_ten == '0) begin
        nxt_sec_ten = 3'd5;
        nxt_min     = ctl.cnt_min - 3'd1;
      end
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      pre                 <= '0;
      ctl.cnt_min         <= '0;
      ctl.cnt_sec_ten     <= '0;
      ctl.cnt_sec_one     <= '0;
      ctl.expired         <= 1'b0;
      ctl.s_strobe        <= 1'b0;
      ctl.s_strobe_fast   <= 1'b0;
      ctl.s_strobe_faster <= 1'b0;
    end else begin
      ctl.s_strobe        <= 1'b0;
      ctl.s_strobe_fast   <= 1'b0;
      ctl.s_strobe_faster <= 1'b0;
      if (ctl.load) begin
        pre             <= '0;
        ctl.expired     <= 1'b0;
        ctl.cnt_min     <= ctl.load_min;
        ctl.cnt_sec_ten <= ctl.load_sec_ten;
        ctl.cnt_sec_one <= ctl.load_sec_one;
      end else if (counting) begin
        pre <= wrap ? '0 : pre + 1'b1;
        if (wrap && (at_zero || at_last)) begin
          // time is up, no strobe from here on
          ctl.expired     <= 1'b1;
          ctl.cnt_min     <= '0;
          ctl.cnt_sec_ten <= '0;
          ctl.cnt_sec_one <= '0;
        end else begin
          if (wrap) begin
            ctl.cnt_min     <= nxt_min;
            ctl.cnt_sec_ten <= nxt_sec_ten;
            ctl.cnt_sec_one <= nxt_sec_one;
          end
          ctl.s_strobe        <= wrap;
          ctl.s_strobe_fast   <= wrap || (pre == PRE_Q2);
          ctl.s_strobe_faster <= wrap || (pre == PRE_Q1) || (pre == PRE_Q2) ||
                                 (pre == PRE_Q3);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tone_voice.sv ====
`timescale 1ns/1ps
`default_nettype none

module tone_voice #(
  parameter int HALF_PERIOD = 4,
  parameter int TOGGLES     = 8
) (
  input  logic clk,
  input  logic nrst,
  input  logic trigger,
  output logic busy,
  output logic wave
);
  import bomb_audio_pkg::*;

  // one extra bit keeps a half period of 1 legal
  localparam int HP_W = $clog2(HALF_PERIOD + 1);
  localparam int TG_W = $clog2(TOGGLES + 1);
  localparam logic [HP_W-1:0] HP_LAST = HP_W'(HALF_PERIOD - 1);
  localparam logic [TG_W-1:0] TG_LAST = TG_W'(TOGGLES - 1);

  voice_state_e    state;
  voice_state_e    nxt_state;
  logic [HP_W-1:0] hp_cnt;
  logic [HP_W-1:0] nxt_hp_cnt;
  logic [TG_W-1:0] tg_cnt;
  logic [TG_W-1:0] nxt_tg_cnt;
  logic            nxt_wave;

  always_comb begin
    nxt_state  = state;
    nxt_hp_cnt = hp_cnt;
    nxt_tg_cnt = tg_cnt;
    nxt_wave   = wave;
    if (trigger) begin
      // restart from the top, even mid tone
      nxt_state  = PLAY;
      nxt_hp_cnt = '0;
      nxt_tg_cnt = '0;
      nxt_wave   = 1'b0;
    end else if (state == PLAY) begin
      if (hp_cnt == HP_LAST) begin
        // half period done
        nxt_hp_cnt = '0;
        nxt_wave   = ~wave;
        nxt_tg_cnt = tg_cnt + 1'b1;
        if (tg_cnt == TG_LAST) begin
          // even toggle count, so wave lands low
          nxt_state  = IDLE;
          nxt_tg_cnt = '0;
        end
      end else begin
        nxt_hp_cnt = hp_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state  <= IDLE;
      hp_cnt <= '0;
      tg_cnt <= '0;
      wave   <= 1'b0;
    end else begin
      state  <= nxt_state;
      hp_cnt <= nxt_hp_cnt;
      tg_cnt <= nxt_tg_cnt;
      wave   <= nxt_wave;
    end
  end

  assign busy = (state == PLAY);

endmodule

`default_nettype wire

// ==== rtl/audio_sm.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_sm #(
  parameter int HP_ERR  = 48000,
  parameter int TG_ERR  = 126,
  parameter int HP_BOOM = 60000,
  parameter int TG_BOOM = 400,
  parameter int HP_PZL  = 20000,
  parameter int TG_PZL  = 100,
  parameter int HP_TICK = 15000,
  parameter int TG_TICK = 100
) (
  input  logic       clk,
  input  logic       nrst,
  game_ctrl_if.audio ctl,
  output logic       audio
);
  import bomb_audio_pkg::*;

  logic       tick_strobe;
  logic       expired_q;
  logic [3:0] trig;
  logic [3:0] v_busy;
  logic [3:0] v_wave;
  logic       nxt_audio;

  // tick rate goes up as time runs low
  always_comb begin
    if ((ctl.cnt_min == '0) && (ctl.cnt_sec_ten <= 3'd1)) begin
      // 0:19 and below
      tick_strobe = ctl.s_strobe_faster;
    end else if ((ctl.cnt_min == '0) && (ctl.cnt_sec_ten <= 3'd3)) begin
      // 0:39 and below
      tick_strobe = ctl.s_strobe_fast;
    end else begin
      tick_strobe = ctl.s_strobe;
    end
  end

  // trigger sources
  assign trig[VOICE_TICK] = tick_strobe;
  assign trig[VOICE_PZL]  = ctl.pzl_evt;
  // boom fires once on the expired edge
  assign trig[VOICE_BOOM] = ctl.expired & ~expired_q;
  assign trig[VOICE_ERR]  = ctl.err_evt;

  tone_voice #(.HALF_PERIOD(HP_TICK), .TOGGLES(TG_TICK)) u_tick (
    .clk     (clk),
    .nrst    (nrst),
    .trigger (trig[VOICE_TICK]),
    .busy    (v_busy[VOICE_TICK]),
    .wave    (v_wave[VOICE_TICK])
  );

  tone_voice #(.HALF_PERIOD(HP_PZL), .TOGGLES(TG_PZL)) u_pzl (
    .clk     (clk),
    .nrst    (nrst),
    .trigger (trig[VOICE_PZL]),
    .busy    (v_busy[VOICE_PZL]),
    .wave    (v_wave[VOICE_PZL])
  );

  tone_voice #(.HALF_PERIOD(HP_BOOM), .TOGGLES(TG_BOOM)) u_boom (
    .clk     (clk),
    .nrst    (nrst),
    .trigger (trig[VOICE_BOOM]),
    .busy    (v_busy[VOICE_BOOM]),
    .wave    (v_wave[VOICE_BOOM])
  );

  tone_voice #(.HALF_PERIOD(HP_ERR), .TOGGLES(TG_ERR)) u_err (
    .clk     (clk),
    .nrst    (nrst),
    .trigger (trig[VOICE_ERR]),
    .busy    (v_busy[VOICE_ERR]),
    .wave    (v_wave[VOICE_ERR])
  );

  // fixed priority: error, boom, puzzle, tick
  always_comb begin
    if (v_busy[VOICE_ERR]) begin
      nxt_audio = v_wave[VOICE_ERR];
    end else if (v_busy[VOICE_BOOM]) begin
      nxt_audio = v_wave[VOICE_BOOM];
    end else if (v_busy[VOICE_PZL]) begin
      nxt_audio = v_wave[VOICE_PZL];
    end else if (v_busy[VOICE_TICK]) begin
      nxt_audio = v_wave[VOICE_TICK];
    end else begin
      nxt_audio = 1'b0;
    end
  end

  // busy is registered with the pin so status matches what is heard
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      audio     <= 1'b0;
      expired_q <= 1'b0;
      ctl.busy  <= '0;
    end else begin
      audio     <= nxt_audio;
      expired_q <= ctl.expired;
      ctl.busy  <= v_busy;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bomb_audio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bomb_audio_top #(
  // prescaler length, one second of clocks
  parameter int TICKS_PER_SEC = 10_000_000,
  // half periods in clocks, lengths in toggles
  parameter int HP_ERR        = 48000,
  parameter int TG_ERR        = 126,
  parameter int HP_BOOM       = 60000,
  parameter int TG_BOOM       = 400,
  parameter int HP_PZL        = 20000,
  parameter int TG_PZL        = 100,
  parameter int HP_TICK       = 15000,
  parameter int TG_TICK       = 100
) (
  input  logic                      clk,
  input  logic                      nrst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  bomb_audio_pkg::apb_addr_t paddr,
  input  bomb_audio_pkg::apb_data_t pwdata,
  output bomb_audio_pkg::apb_data_t prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      audio
);

  // control and status between the blocks
  game_ctrl_if u_ctl ();

  game_apb_regs u_regs (
    .clk     (clk),
    .nrst    (nrst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ctl     (u_ctl)
  );

  countdown_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_timer (
    .clk  (clk),
    .nrst (nrst),
    .ctl  (u_ctl)
  );

  audio_sm #(
    .HP_ERR  (HP_ERR),
    .TG_ERR  (TG_ERR),
    .HP_BOOM (HP_BOOM),
    .TG_BOOM (TG_BOOM),
    .HP_PZL  (HP_PZL),
    .TG_PZL  (TG_PZL),
    .HP_TICK (HP_TICK),
    .TG_TICK (TG_TICK)
  ) u_audio (
    .clk   (clk),
    .nrst  (nrst),
    .ctl   (u_ctl),
    .audio (audio)
  );

endmodule

`default_nettype wire

// ==== tests/bomb_audio_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module bomb_audio_assert #(
  // audio pin checks instead of the bus side checks
  parameter bit AUDIO_SIDE = 1'b0
) (
  input logic       clk,
  input logic       nrst,
  input logic       penable,
  input logic       pready,
  input logic       err_evt,
  input logic       pzl_evt,
  input logic [3:0] busy,
  input logic       audio
);

  if (AUDIO_SIDE) begin : g_audio
    // silent pin with all voices idle
    a_quiet: assert property (@(posedge clk) disable iff (!nrst) (busy == 4'b0) |-> !audio)
      else $error("audio high with no voice busy");
  end else begin : g_bus
    // no wait states on this bus
    a_pready: assert property (@(posedge clk) disable iff (!nrst) penable |-> pready)
      else $error("pready low in an access cycle");

    // event pulses are single cycle
    a_err_pulse: assert property (@(posedge clk) disable iff (!nrst) err_evt |=> !err_evt)
      else $error("error event longer than one cycle");

    a_pzl_pulse: assert property (@(posedge clk) disable iff (!nrst) pzl_evt |=> !pzl_evt)
      else $error("puzzle event longer than one cycle");
  end

endmodule

bind game_apb_regs bomb_audio_assert u_regs_chk (
  .clk (clk), .nrst (nrst), .penable (penable), .pready (pready),
  .err_evt (ctl.err_evt), .pzl_evt (ctl.pzl_evt), .busy (ctl.busy), .audio (1'b0)
);

bind audio_sm bomb_audio_assert #(.AUDIO_SIDE(1'b1)) u_audio_chk (
  .clk (clk), .nrst (nrst), .penable (1'b0), .pready (1'b1),
  .err_evt (ctl.err_evt), .pzl_evt (ctl.pzl_evt), .busy (ctl.busy), .audio (audio)
);

`default_nettype wire

// ==== tests/bomb_audio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bomb_audio_tb;
  import bomb_audio_pkg::*;

  localparam int TICKS   = 16;
  localparam int HP_ERR  = 3;
  localparam int TG_ERR  = 8;
  localparam int HP_BOOM = 5;
  localparam int TG_BOOM = 12;
  localparam int HP_PZL  = 4;
  localparam int TG_PZL  = 6;
  localparam int HP_TICK = 1;
  localparam int TG_TICK = 2;
  // time change to tick edge on the pin takes 3 cycles plus one spare
  localparam int SETTLE  = 4;
  localparam int MAX_ENT = 48;

  typedef enum int {OP_WR, OP_RD, OP_EV, OP_WAIT} op_e;

  typedef struct {
    op_e       op;
    apb_addr_t addr;
    apb_data_t data;
    apb_data_t exp;
    logic      exp_err;
    int        edges;
    int        width;
    int        win;
    int        behavior;
  } entry_t;

  logic      clk;
  logic      nrst;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      audio;

  entry_t tbl [MAX_ENT];
  int     n_ent;
  int     seed;
  int     n_checks;
  int     n_errors;
  int     cycles;
  int     limit;
  int     rises;
  int     high_w;
  logic   audio_q;
  int     widths [$];
  int     prev_secs;

  bomb_audio_top #(
    .TICKS_PER_SEC (TICKS),
    .HP_ERR        (HP_ERR),
    .TG_ERR        (TG_ERR),
    .HP_BOOM       (HP_BOOM),
    .TG_BOOM       (TG_BOOM),
    .HP_PZL        (HP_PZL),
    .TG_PZL        (TG_PZL),
    .HP_TICK       (HP_TICK),
    .TG_TICK       (TG_TICK)
  ) u_dut (
    .clk     (clk),
    .nrst    (nrst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .audio   (audio)
  );

  initial begin
    clk = 1'b1;
    forever #2 clk = ~clk;
  end

  // run limit on the falling edges counted by step
  always @(posedge clk) begin
    if (cycles > limit) begin
      $display("timeout: no finish after %0d cycles, limit was %0d", cycles, limit);
      $display("test failed");
      $finish;
    end
  end

  // one falling edge with the audio pin measured on the way
  task automatic step();
    @(negedge clk);
    cycles++;
    if (audio && !audio_q) begin
      rises++;
      high_w = 1;
    end else if (audio) begin
      high_w++;
    end else if (audio_q) begin
      // high pulse just ended
      widths.push_back(high_w);
    end
    audio_q = audio;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR @%0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // setup then access with the response taken at the next falling edge
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    step();
    penable = 1'b1;
    step();
    check_value("pready in access cycle", 32'(pready), 32'h1);
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    step();
    penable = 1'b1;
    step();
    check_value("pready in access cycle", 32'(pready), 32'h1);
    data    = prdata;
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic apb_data_t time_word(input int m, input int t, input int o);
    return apb_data_t'((m << 8) | (t << 4) | o);
  endfunction

  function automatic int to_secs(input apb_data_t w);
    return 60 * int'(w[10:8]) + 10 * int'(w[6:4]) + int'(w[3:0]);
  endfunction

  // ticks heard while the count falls from hi to lo seconds
  function automatic int tick_edges(input int hi, input int lo);
    int n;
    n = 0;
    for (int c = lo; c <= hi; c++) begin
      // every second step ticks but the step into 0:00 does not
      if (c < hi && c > 0) n++;
      // extra ticks inside each fully counted second
      if (c > lo) n += (c <= 19) ? 3 : (c <= 39) ? 1 : 0;
    end
    return n;
  endfunction

  function automatic string op_name(input op_e op);
    case (op)
      OP_WR:   return "write";
      OP_RD:   return "read";
      OP_EV:   return "event";
      default: return "wait-time";
    endcase
  endfunction

  task automatic add_entry(input op_e op, input apb_addr_t addr, input apb_data_t data,
                           input apb_data_t exp, input logic err, input int edges,
                           input int width, input int win, input int beh);
    tbl[n_ent] = '{op, addr, data, exp, err, edges, width, win, beh};
    n_ent++;
  endtask

  task automatic build_table();
    apb_data_t w;
    w = '0;
    // random legal times read back while stopped
    for (int k = 0; k < 4; k++) begin
      w = time_word({$random(seed)} % 8, {$random(seed)} % 6, {$random(seed)} % 10);
      add_entry(OP_WR, ADDR_TIME, w, 0, 1'b0, -1, 0, 0, 1);
      add_entry(OP_RD, ADDR_TIME, 0, w, 1'b0, -1, 0, 0, 1);
    end
    // bad accesses each followed by a read that shows nothing moved
    add_entry(OP_WR, 8'h01, 32'h3, 0, 1'b1, 0, 0, 0, 1);
    add_entry(OP_RD, ADDR_CTRL, 0, 0, 1'b0, 0, 0, 0, 1);
    add_entry(OP_WR, 8'h06, 32'h0759, 0, 1'b1, 0, 0, 0, 1);
    add_entry(OP_RD, ADDR_TIME, 0, w, 1'b0, 0, 0, 0, 1);
    add_entry(OP_WR, 8'h10, 32'h0205, 0, 1'b1, 0, 0, 0, 1);
    add_entry(OP_RD, 8'h10, 0, 0, 1'b1, 0, 0, 0, 1);
    add_entry(OP_WR, ADDR_STATUS, 32'h1F, 0, 1'b1, 0, 0, 0, 1);
    add_entry(OP_RD, ADDR_STATUS, 0, 0, 1'b0, 0, 0, 0, 1);
    add_entry(OP_RD, ADDR_EVENT, 0, 0, 1'b0, 0, 0, 0, 1);
    add_entry(OP_RD, ADDR_TIME, 0, w, 1'b0, 0, 0, 0, 1);
    // error buzz alone
    add_entry(OP_EV, ADDR_EVENT, 32'h01, 32'h1 << VOICE_ERR, 1'b0, TG_ERR / 2, HP_ERR,
              TG_ERR * HP_ERR + 16, 2);
    add_entry(OP_RD, ADDR_STATUS, 0, 0, 1'b0, 0, 0, 0, 2);
    // puzzle then error two cycles later so the puzzle finishes under the buzz
    add_entry(OP_EV, ADDR_EVENT, 32'h0102, (32'h1 << VOICE_ERR) | (32'h1 << VOICE_PZL),
              1'b0, TG_ERR / 2, HP_ERR, TG_ERR * HP_ERR + 16, 3);
    add_entry(OP_RD, ADDR_STATUS, 0, 0, 1'b0, 0, 0, 0, 3);
    // countdown from 0:42 through the three tick rates
    add_entry(OP_WR, ADDR_TIME, time_word(0, 4, 2), 0, 1'b0, 0, 0, 0, 4);
    add_entry(OP_RD, ADDR_TIME, 0, time_word(0, 4, 2), 1'b0, 0, 0, 0, 4);
    add_entry(OP_WR, ADDR_CTRL, 32'h1, 0, 1'b0, -1, 0, 0, 4);
    add_entry(OP_WAIT, ADDR_TIME, time_word(0, 4, 0), 0, 1'b0, tick_edges(42, 40), HP_TICK, 0, 4);
    add_entry(OP_WAIT, ADDR_TIME, time_word(0, 3, 9), 0, 1'b0, tick_edges(40, 39), HP_TICK, 0, 4);
    add_entry(OP_WAIT, ADDR_TIME, time_word(0, 2, 0), 0, 1'b0, tick_edges(39, 20), HP_TICK, 0, 4);
    add_entry(OP_WAIT, ADDR_TIME, time_word(0, 1, 9), 0, 1'b0, tick_edges(20, 19), HP_TICK, 0, 4);
    add_entry(OP_WAIT, ADDR_TIME, 0, 0, 1'b0, tick_edges(19, 0), HP_TICK, 0, 4);
    // boom once and then silence
    add_entry(OP_WAIT, ADDR_TIME, 0, 0, 1'b0, TG_BOOM / 2, HP_BOOM, TG_BOOM * HP_BOOM + 40, 5);
    add_entry(OP_RD, ADDR_STATUS, 0, 32'h10, 1'b0, 0, 0, 0, 5);
    add_entry(OP_RD, ADDR_TIME, 0, 0, 1'b0, 0, 0, 0, 5);
    add_entry(OP_WR, ADDR_CTRL, 32'h0, 0, 1'b0, 0, 0, 0, 5);
    add_entry(OP_WR, ADDR_TIME, time_word(0, 0, 5), 0, 1'b0, 0, 0, 0, 5);
    add_entry(OP_RD, ADDR_STATUS, 0, 0, 1'b0, 0, 0, 0, 5);
    add_entry(OP_RD, ADDR_TIME, 0, time_word(0, 0, 5), 1'b0, 0, 0, 0, 5);
  endtask

  task automatic run_entry(input int i);
    entry_t    e;
    apb_data_t rd;
    logic      err;
    int        errs_before;
    logic      found;
    e = tbl[i];
    errs_before = n_errors;
    rises = 0;
    widths.delete();
    case (e.op)
      OP_WR: begin
        apb_write(e.addr, e.data, err);
        check_value("pslverr on write", 32'(err), 32'(e.exp_err));
      end
      OP_RD: begin
        apb_read(e.addr, rd, err);
        check_value("pslverr on read", 32'(err), 32'(e.exp_err));
        check_value("read data", rd, e.exp);
      end
      OP_EV: begin
        apb_write(e.addr, {24'h0, e.data[7:0]}, err);
        check_value("pslverr on event", 32'(err), 32'h0);
        // optional second event right behind the first
        if (e.data[15:8] != 8'h0) begin
          apb_write(e.addr, {24'h0, e.data[15:8]}, err);
          check_value("pslverr on event", 32'(err), 32'h0);
        end
        apb_read(ADDR_STATUS, rd, err);
        check_value("status while playing", rd, e.exp);
        repeat (e.win) step();
      end
      OP_WAIT: begin
        found = 1'b0;
        while (!found) begin
          apb_read(e.addr, rd, err);
          check_value("time never counts up", 32'(to_secs(rd) <= prev_secs), 32'h1);
          prev_secs = to_secs(rd);
          found = (rd == e.data);
        end
        repeat (SETTLE + e.win) step();
      end
      default: begin
        n_errors++;
        $display("table entry %0d has an unknown operation", i);
      end
    endcase
    if (e.edges >= 0) check_value("audio rising edges", 32'(rises), 32'(e.edges));
    if (e.width > 0) begin
      foreach (widths[k]) check_value("audio high width", 32'(widths[k]), 32'(e.width));
    end
    $display("entry %0d, behavior %0d, %s at %0h: %0d edges, %s", i, e.behavior,
             op_name(e.op), e.addr, rises, (n_errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    nrst      = 1'b0;
    seed      = 8702;
    n_ent     = 0;
    n_checks  = 0;
    n_errors  = 0;
    cycles    = 0;
    rises     = 0;
    high_w    = 0;
    audio_q   = 1'b0;
    prev_secs = 32'h7fff_ffff;
    build_table();
    // whole countdown plus every window and some slack per entry
    limit = 42 * TICKS + 200;
    for (int k = 0; k < n_ent; k++) limit += tbl[k].win + SETTLE + 24;
    repeat (8) step();
    nrst = 1'b1;
    step();
    for (int k = 0; k < n_ent; k++) run_entry(k);
    $display("%0d entries, %0d checks, %0d errors", n_ent, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/bomb_audio_pkg.sv
rtl/game_ctrl_if.sv
rtl/game_apb_regs.sv
rtl/countdown_timer.sv
rtl/tone_voice.sv
rtl/audio_sm.sv
rtl/bomb_audio_top.sv
tests/bomb_audio_assert.sv
tests/bomb_audio_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module bomb_audio_tb -o bomb_audio_sim

sim_out=$(./obj_dir/bomb_audio_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'test passed'; then
  exit 0
fi
exit 1
